/* src/exu_pkg.sv */
// Shared definitions for the execute stage.
// Holds the data width, the operation and operand-select encodings, and the
// two structs that cross the decode/execute and execute/LSU boundaries.
// Every stage file imports what it needs from here.

`default_nettype none

package exu_pkg;

	parameter int xlen = 32;

	// ALU operation codes, 11 of 16 used
	typedef enum logic [3:0] {
		alu_add       = 4'd0,
		alu_sub       = 4'd1,
		alu_sll       = 4'd2,
		alu_slt       = 4'd3,
		alu_sltu      = 4'd4,
		alu_xor       = 4'd5,
		alu_srl       = 4'd6,
		alu_sra       = 4'd7,
		alu_or        = 4'd8,
		alu_and       = 4'd9,
		alu_pass_src2 = 4'd10
	} alu_op_e;

	typedef enum logic [1:0] {
		src1_zero = 2'd0,
		src1_reg1 = 2'd1,
		src1_pc   = 2'd2,
		src1_csr  = 2'd3
	} src1_sel_e;

	typedef enum logic [1:0] {
		src2_zero = 2'd0,
		src2_reg2 = 2'd1,
		src2_imm  = 2'd2,
		src2_four = 2'd3
	} src2_sel_e;

	typedef enum logic [2:0] {
		csr_none = 3'd0,
		csr_rw   = 3'd1,
		csr_rs   = 3'd2,
		csr_rc   = 3'd3
	} csr_op_e;

	typedef enum logic [2:0] {
		load_none = 3'd0,
		load_lb   = 3'd1,
		load_lh   = 3'd2,
		load_lw   = 3'd3,
		load_lbu  = 3'd4,
		load_lhu  = 3'd5
	} load_type_e;

	// store_none doubles as "no memory write" for the LSU
	typedef enum logic [1:0] {
		store_none = 2'd0,
		store_sb   = 2'd1,
		store_sh   = 2'd2,
		store_sw   = 2'd3
	} store_type_e;

	// decoded instruction from the decode stage
	typedef struct packed {
		logic [xlen-1:0] reg1;
		logic [xlen-1:0] reg2;
		logic [xlen-1:0] pc;
		logic [xlen-1:0] imm;
		logic [xlen-1:0] csr_rdata;
		alu_op_e         alu_op;
		src1_sel_e       src1_sel;
		src2_sel_e       src2_sel;
		csr_op_e         csr_op;
		load_type_e      load_type;
		store_type_e     store_type;
		logic            wd;
		logic [4:0]      wreg;
		logic            ebreak;
	} id_exu_t;

	// execute result handed to the load/store stage
	typedef struct packed {
		logic [xlen-1:0] alu_result;
		logic [xlen-1:0] mem_wdata;
		logic [xlen-1:0] csr_wdata;
		logic [xlen-1:0] pc;
		load_type_e      load_type;
		store_type_e     store_type;
		csr_op_e         csr_op;
		logic            wd;
		logic [4:0]      wreg;
		logic            ebreak;
	} exu_lsu_t;

endpackage

`default_nettype wire

/* src/exu_ctrl.sv */
// Handshake controller of the execute stage.
// Accepts one instruction from decode while idle, presents it to the LSU
// the cycle after, and holds it until the LSU takes it. Only one
// instruction is ever in flight, so ready and valid never overlap.

`timescale 1ns/10ps
`default_nettype none

module exu_ctrl (
	input  logic clock,
	input  logic reset,
	input  logic id_valid_i,
	input  logic lsu_ready_i,
	output logic exu_ready_o,
	output logic exu_valid_o,
	output logic capture_o
);

	typedef enum logic [1:0] {
		st_idle     = 2'b00,
		st_run      = 2'b01,
		st_wait_lsu = 2'b10
	} state_e;

	state_e state;
	state_e next_state;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= st_idle;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			st_idle: begin
				if (id_valid_i) begin
					next_state = st_run;
				end
			end
			// first cycle with a result on the outputs
			st_run: begin
				if (lsu_ready_i) begin
					next_state = st_idle;
				end else begin
					next_state = st_wait_lsu;
				end
			end
			st_wait_lsu: begin
				if (lsu_ready_i) begin
					next_state = st_idle;
				end
			end
			// unused encoding falls back to idle
			default: begin
				next_state = st_idle;
			end
		endcase
	end

	assign exu_ready_o = (state == st_idle);
	assign exu_valid_o = (state == st_run) || (state == st_wait_lsu);
	assign capture_o   = exu_ready_o && id_valid_i;

endmodule

`default_nettype wire

/* src/exu_issue_reg.sv */
// Holding register for the instruction accepted from decode.
// Loads the decoded struct on the capture pulse and keeps it until the
// next capture, so decode may change its outputs right after the accept
// and the stage still works on what it took.

`timescale 1ns/10ps
`default_nettype none

module exu_issue_reg (
	input  logic             clock,
	input  logic             reset,
	input  logic             capture_i,
	input  exu_pkg::id_exu_t id_data_i,
	output exu_pkg::id_exu_t held_o
);

	// cleared so an idle stage shows an all-zero instruction
	always_ff @(posedge clock) begin
		if (reset) begin
			held_o <= '0;
		end else if (capture_i) begin
			held_o <= id_data_i;
		end
	end

endmodule

`default_nettype wire

/* src/exu_operand_sel.sv */
// Operand multiplexers in front of the ALU.
// Operand 1 comes from zero, reg1, pc or the CSR read data, and operand 2
// from zero, reg2, the immediate or the constant four used for link
// addresses. Purely combinational.

`timescale 1ns/10ps
`default_nettype none

module exu_operand_sel (
	input  exu_pkg::id_exu_t         held_i,
	output logic [exu_pkg::xlen-1:0] src1_o,
	output logic [exu_pkg::xlen-1:0] src2_o
);

	import exu_pkg::*;

	always_comb begin
		case (held_i.src1_sel)
			src1_zero: src1_o = '0;
			src1_reg1: src1_o = held_i.reg1;
			src1_pc:   src1_o = held_i.pc;
			src1_csr:  src1_o = held_i.csr_rdata;
			default:   src1_o = '0;
		endcase
	end

	always_comb begin
		case (held_i.src2_sel)
			src2_zero: src2_o = '0;
			src2_reg2: src2_o = held_i.reg2;
			src2_imm:  src2_o = held_i.imm;
			// pc + 4 for jal and jalr
			src2_four: src2_o = xlen'(4);
			default:   src2_o = '0;
		endcase
	end

endmodule

`default_nettype wire

/* src/exu_alu.sv */
// RV32I integer ALU.
// Add, subtract, logic, shift and set-less-than on two operands, plus a
// pass of operand 2 for lui. Shift amounts are the low five bits of
// operand 2. Combinational, an unknown code yields zero.

`timescale 1ns/10ps
`default_nettype none

module exu_alu (
	input  logic [exu_pkg::xlen-1:0] src1_i,
	input  logic [exu_pkg::xlen-1:0] src2_i,
	input  exu_pkg::alu_op_e         op_i,
	output logic [exu_pkg::xlen-1:0] result_o
);

	import exu_pkg::*;

	logic [4:0] shamt;
	logic       lt_signed;
	logic       lt_unsigned;

	assign shamt       = src2_i[4:0];
	assign lt_signed   = $signed(src1_i) < $signed(src2_i);
	assign lt_unsigned = src1_i < src2_i;

	always_comb begin
		case (op_i)
			alu_add: begin
				result_o = src1_i + src2_i;
			end
			alu_sub: begin
				result_o = src1_i - src2_i;
			end
			alu_sll: begin
				result_o = src1_i << shamt;
			end
			alu_slt: begin
				result_o = {{(xlen-1){1'b0}}, lt_signed};
			end
			alu_sltu: begin
				result_o = {{(xlen-1){1'b0}}, lt_unsigned};
			end
			alu_xor: begin
				result_o = src1_i ^ src2_i;
			end
			alu_srl: begin
				result_o = src1_i >> shamt;
			end
			// arithmetic shift keeps the sign bit
			alu_sra: begin
				result_o = $unsigned($signed(src1_i) >>> shamt);
			end
			alu_or: begin
				result_o = src1_i | src2_i;
			end
			alu_and: begin
				result_o = src1_i & src2_i;
			end
			alu_pass_src2: begin
				result_o = src2_i;
			end
			default: begin
				result_o = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

/* src/exu_csr_wdata.sv */
// Write data for the CSR instructions.
// csrrw writes rs1, csrrs sets the rs1 bits in the old value and csrrc
// clears them. Non-CSR instructions give zero. Combinational.

`timescale 1ns/10ps
`default_nettype none

module exu_csr_wdata (
	input  exu_pkg::csr_op_e         op_i,
	input  logic [exu_pkg::xlen-1:0] rs1_i,
	input  logic [exu_pkg::xlen-1:0] csr_rdata_i,
	output logic [exu_pkg::xlen-1:0] wdata_o
);

	import exu_pkg::*;

	always_comb begin
		case (op_i)
			csr_rw:  wdata_o = rs1_i;
			csr_rs:  wdata_o = csr_rdata_i | rs1_i;
			csr_rc:  wdata_o = csr_rdata_i & ~rs1_i;
			default: wdata_o = '0;
		endcase
	end

endmodule

`default_nettype wire

/* src/exu_top.sv */
// Execute stage of the in-order RV32 core.
// Takes one decoded instruction from decode over a valid/ready pair,
// registers it, computes the ALU result and CSR write data, and offers
// the result to the LSU over a second valid/ready pair. The result stays
// stable while the LSU stalls. Accept to earliest handoff is one cycle.

`timescale 1ns/10ps
`default_nettype none

module exu_top (
	input  logic              clock,
	input  logic              reset,
	input  logic              id_valid_i,
	input  exu_pkg::id_exu_t  id_data_i,
	output logic              exu_ready_o,
	output logic              exu_valid_o,
	output exu_pkg::exu_lsu_t exu_data_o,
	input  logic              lsu_ready_i
);

	import exu_pkg::*;

	logic            capture;
	id_exu_t         held;
	logic [xlen-1:0] src1;
	logic [xlen-1:0] src2;
	logic [xlen-1:0] alu_result;
	logic [xlen-1:0] csr_wdata;

	exu_ctrl u_exu_ctrl (
		.clock       (clock),
		.reset       (reset),
		.id_valid_i  (id_valid_i),
		.lsu_ready_i (lsu_ready_i),
		.exu_ready_o (exu_ready_o),
		.exu_valid_o (exu_valid_o),
		.capture_o   (capture)
	);

	exu_issue_reg u_exu_issue_reg (
		.clock     (clock),
		.reset     (reset),
		.capture_i (capture),
		.id_data_i (id_data_i),
		.held_o    (held)
	);

	exu_operand_sel u_exu_operand_sel (
		.held_i (held),
		.src1_o (src1),
		.src2_o (src2)
	);

	exu_alu u_exu_alu (
		.src1_i   (src1),
		.src2_i   (src2),
		.op_i     (held.alu_op),
		.result_o (alu_result)
	);

	exu_csr_wdata u_exu_csr_wdata (
		.op_i        (held.csr_op),
		.rs1_i       (held.reg1),
		.csr_rdata_i (held.csr_rdata),
		.wdata_o     (csr_wdata)
	);

	// everything below is derived from the held struct, hence stable
	// for as long as the instruction waits for the LSU
	assign exu_data_o.alu_result = alu_result;
	assign exu_data_o.mem_wdata  = held.reg2;
	assign exu_data_o.csr_wdata  = csr_wdata;
	assign exu_data_o.pc         = held.pc;
	assign exu_data_o.load_type  = held.load_type;
	assign exu_data_o.store_type = held.store_type;
	assign exu_data_o.csr_op     = held.csr_op;
	assign exu_data_o.wd         = held.wd;
	assign exu_data_o.wreg       = held.wreg;
	assign exu_data_o.ebreak     = held.ebreak;

endmodule

`default_nettype wire

/* verification/exu_properties.sv */
// Handshake assertions for the execute stage.
// Bound into every exu_top instance, watches both valid/ready pairs and
// the capture pulse.

`timescale 1ns/10ps
`default_nettype none

module exu_properties (
	input logic              clock,
	input logic              reset,
	input logic              exu_ready_i,
	input logic              exu_valid_i,
	input exu_pkg::exu_lsu_t exu_data_i,
	input logic              lsu_ready_i,
	input logic              capture_i
);

	int assert_failures = 0;

	// one instruction at most, so exactly one side is open at a time
	a_no_overlap: assert property (@(posedge clock) disable iff (reset)
		exu_ready_i != exu_valid_i)
		else begin
			assert_failures++;
			$error("both or neither of exu_ready_o and exu_valid_o high");
		end

	a_hold_until_handoff: assert property (@(posedge clock) disable iff (reset)
		exu_valid_i && !lsu_ready_i |=> exu_valid_i && $stable(exu_data_i))
		else begin
			assert_failures++;
			$error("result dropped or changed before the LSU took it");
		end

	// capture only from idle, and the result is offered one edge later
	a_capture_when_ready: assert property (@(posedge clock) disable iff (reset)
		capture_i |-> exu_ready_i ##1 (exu_valid_i && !exu_ready_i))
		else begin
			assert_failures++;
			$error("capture while busy or no result offered after it");
		end

endmodule

bind exu_top exu_properties u_exu_properties (
	.clock       (clock),
	.reset       (reset),
	.exu_ready_i (exu_ready_o),
	.exu_valid_i (exu_valid_o),
	.exu_data_i  (exu_data_o),
	.lsu_ready_i (lsu_ready_i),
	.capture_i   (capture)
);

`default_nettype wire

/* verification/tb_exu.sv */
// Directed testbench for the execute stage.
// Runs reset, an ALU and operand-select sweep, CSR write data,
// back-pressure, capture isolation and a random stream against a
// reference model built from the ALU and CSR rules.

`timescale 1ns/10ps
`default_nettype none

module tb_exu;

	import exu_pkg::*;

	// worst case of all tests is about 1600 cycles
	localparam int timeout_cycles = 3000;

	logic      clock;
	logic      reset;
	logic      id_valid_i;
	id_exu_t   id_data_i;
	logic      exu_ready_o;
	logic      exu_valid_o;
	exu_lsu_t  exu_data_o;
	logic      lsu_ready_i;
	logic [31:0] lfsr_q = 32'hf5d5_f08a;
	int        cycle_count = 0;
	int        handoffs = 0;
	int        sent = 0;

	exu_top u_exu_top (
		.clock       (clock),
		.reset       (reset),
		.id_valid_i  (id_valid_i),
		.id_data_i   (id_data_i),
		.exu_ready_o (exu_ready_o),
		.exu_valid_o (exu_valid_o),
		.exu_data_o  (exu_data_o),
		.lsu_ready_i (lsu_ready_i)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	always @(posedge clock) begin
		cycle_count++;
		if (!reset && exu_valid_o && lsu_ready_i) begin
			handoffs++;
		end
		if (cycle_count >= timeout_cycles) begin
			$display("Timeout after %0d cycles, the handshake stopped moving", cycle_count);
			$display("Test failed");
			$fatal(1, "timeout");
		end
	end

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_next(lfsr_q);
			v = {v[30:0], lfsr_q[0]};
		end
		return v;
	endfunction

	function automatic logic [31:0] model_alu(input alu_op_e op, input logic [31:0] a,
			input logic [31:0] b);
		logic [4:0]  sh;
		logic [31:0] fill;
		sh = b[4:0];
		fill = a[31] ? ~(32'hffff_ffff >> sh) : 32'h0;
		case (op)
			alu_add:       return a + b;
			alu_sub:       return a - b;
			alu_sll:       return a << sh;
			// flipping the sign bits turns a signed compare into unsigned
			alu_slt:       return 32'((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000));
			alu_sltu:      return 32'(a < b);
			alu_xor:       return a ^ b;
			alu_srl:       return a >> sh;
			alu_sra:       return (a >> sh) | fill;
			alu_or:        return a | b;
			alu_and:       return a & b;
			alu_pass_src2: return b;
			default:       return 32'h0;
		endcase
	endfunction

	function automatic logic [31:0] model_csr(input csr_op_e op, input logic [31:0] rs1,
			input logic [31:0] rdata);
		case (op)
			csr_rw:  return rs1;
			csr_rs:  return rdata | rs1;
			csr_rc:  return rdata & ~rs1;
			default: return 32'h0;
		endcase
	endfunction

	function automatic exu_lsu_t model_result(input id_exu_t d);
		exu_lsu_t r;
		logic [31:0] s1;
		logic [31:0] s2;
		case (d.src1_sel)
			src1_reg1: s1 = d.reg1;
			src1_pc:   s1 = d.pc;
			src1_csr:  s1 = d.csr_rdata;
			default:   s1 = 32'h0;
		endcase
		case (d.src2_sel)
			src2_reg2: s2 = d.reg2;
			src2_imm:  s2 = d.imm;
			src2_four: s2 = 32'd4;
			default:   s2 = 32'h0;
		endcase
		r.alu_result = model_alu(d.alu_op, s1, s2);
		r.mem_wdata  = d.reg2;
		r.csr_wdata  = model_csr(d.csr_op, d.reg1, d.csr_rdata);
		r.pc         = d.pc;
		r.load_type  = d.load_type;
		r.store_type = d.store_type;
		r.csr_op     = d.csr_op;
		r.wd         = d.wd;
		r.wreg       = d.wreg;
		r.ebreak     = d.ebreak;
		return r;
	endfunction

	// overflow, sign boundary and shift amounts hidden in negative values
	function automatic logic [31:0] edge_value(input int k);
		case (k % 6)
			0:       return 32'h7fff_ffff;
			1:       return 32'h8000_0000;
			2:       return 32'hffff_ffe4;
			3:       return 32'h0000_0001;
			4:       return 32'hffff_ffff;
			default: return 32'h0000_0024;
		endcase
	endfunction

	function automatic id_exu_t rand_instr();
		id_exu_t d;
		d.reg1       = rand_bits(32);
		d.reg2       = rand_bits(32);
		d.pc         = rand_bits(32);
		d.imm        = rand_bits(32);
		d.csr_rdata  = rand_bits(32);
		d.alu_op     = alu_op_e'(4'(rand_bits(4) % 32'd11));
		d.src1_sel   = src1_sel_e'(2'(rand_bits(2)));
		d.src2_sel   = src2_sel_e'(2'(rand_bits(2)));
		d.csr_op     = csr_op_e'(3'(rand_bits(2)));
		d.load_type  = load_type_e'(3'(rand_bits(3) % 32'd6));
		d.store_type = store_type_e'(2'(rand_bits(2)));
		d.wd         = rand_bits(1) != 0;
		d.wreg       = 5'(rand_bits(5));
		d.ebreak     = rand_bits(1) != 0;
		return d;
	endfunction

	task automatic check(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("ERROR at %0t: %s expected %h actual %h", $time, name, expected, actual);
			$display("Test failed");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic check_result(input exu_lsu_t e);
		check("alu_result", e.alu_result, exu_data_o.alu_result);
		check("mem_wdata", e.mem_wdata, exu_data_o.mem_wdata);
		check("csr_wdata", e.csr_wdata, exu_data_o.csr_wdata);
		check("pc", e.pc, exu_data_o.pc);
		check("load_type", 32'(e.load_type), 32'(exu_data_o.load_type));
		check("store_type", 32'(e.store_type), 32'(exu_data_o.store_type));
		check("csr_op", 32'(e.csr_op), 32'(exu_data_o.csr_op));
		check("wd", 32'(e.wd), 32'(exu_data_o.wd));
		check("wreg", 32'(e.wreg), 32'(exu_data_o.wreg));
		check("ebreak", 32'(e.ebreak), 32'(exu_data_o.ebreak));
	endtask

	task automatic step();
		@(posedge clock);
		#1;
	endtask

	// decode keeps valid up and scrambles its data right after the accept
	task automatic send(input id_exu_t d);
		id_valid_i = 1'b1;
		id_data_i = d;
		while (!exu_ready_o) begin
			step();
		end
		step();
		id_data_i = id_exu_t'(~d);
	endtask

	task automatic run_one(input id_exu_t d, input int stall);
		exu_lsu_t e;
		e = model_result(d);
		lsu_ready_i = (stall == 0);
		send(d);
		check("exu_valid_o", 1, 32'(exu_valid_o));
		check("exu_ready_o", 0, 32'(exu_ready_o));
		check_result(e);
		for (int i = 0; i < stall; i++) begin
			step();
			check("exu_valid_o", 1, 32'(exu_valid_o));
			check("exu_ready_o", 0, 32'(exu_ready_o));
			check_result(e);
		end
		lsu_ready_i = 1'b1;
		step();
		id_valid_i = 1'b0;
		lsu_ready_i = 1'b0;
		check("exu_valid_o", 0, 32'(exu_valid_o));
		check("exu_ready_o", 1, 32'(exu_ready_o));
		sent++;
	endtask

	task automatic test_reset();
		check("exu_ready_o", 1, 32'(exu_ready_o));
		check("exu_valid_o", 0, 32'(exu_valid_o));
		// held instruction is cleared, so the outputs show an all-zero one
		check_result(model_result('0));
	endtask

	task automatic test_alu_sweep();
		id_exu_t d;
		int k;
		k = 0;
		for (int op = 0; op < 11; op++) begin
			for (int sel = 0; sel < 16; sel++) begin
				d = '0;
				d.reg1      = edge_value(k);
				d.reg2      = edge_value(k + 1);
				d.imm       = edge_value(k + 2);
				d.csr_rdata = edge_value(k + 3);
				d.pc        = 32'h0000_1000 + 32'(k * 4);
				d.alu_op    = alu_op_e'(4'(op));
				d.src1_sel  = src1_sel_e'(2'(sel / 4));
				d.src2_sel  = src2_sel_e'(2'(sel % 4));
				run_one(d, 0);
				k++;
			end
		end
	endtask

	task automatic test_csr();
		id_exu_t d;
		for (int op = 0; op < 4; op++) begin
			for (int v = 0; v < 3; v++) begin
				d = '0;
				d.reg1      = (v == 0) ? 32'h0000_00ff : (v == 1) ? 32'hffff_ffff : 32'h0;
				d.csr_rdata = (v == 0) ? 32'hf0f0_f0f0 : (v == 1) ? 32'h1234_5678 : 32'h8000_0301;
				d.csr_op    = csr_op_e'(3'(op));
				d.src1_sel  = src1_csr;
				d.wd        = 1'b1;
				run_one(d, 0);
			end
		end
	endtask

	task automatic test_backpressure();
		run_one(rand_instr(), 6);
		run_one(rand_instr(), 0);
	endtask

	task automatic test_passthrough();
		id_exu_t d;
		d = rand_instr();
		d.reg2       = 32'hcafe_f00d;
		d.pc         = 32'h0000_2468;
		d.load_type  = load_lw;
		d.store_type = store_sw;
		d.wd         = 1'b1;
		d.wreg       = 5'd17;
		d.ebreak     = 1'b1;
		run_one(d, 3);
	endtask

	task automatic test_random_stream();
		for (int n = 0; n < 200; n++) begin
			repeat (rand_bits(1)) step();
			run_one(rand_instr(), int'(rand_bits(2)));
		end
		check("handoff count", 32'(sent), 32'(handoffs));
	endtask

	initial begin
		reset = 1'b1;
		id_valid_i = 1'b0;
		id_data_i = '0;
		lsu_ready_i = 1'b0;
		repeat (16) @(posedge clock);
		#1;
		reset = 1'b0;
		test_reset();
		test_alu_sweep();
		test_csr();
		test_backpressure();
		test_passthrough();
		test_random_stream();
		step();
		if (u_exu_top.u_exu_properties.assert_failures == 0) begin
			$display("Test completed successfully");
			$finish;
		end else begin
			$display("%0d handshake assertions failed",
				u_exu_top.u_exu_properties.assert_failures);
			$display("Test failed");
			$fatal(1, "assertion failures");
		end
	end

endmodule

`default_nettype wire

/* build.f */
src/exu_pkg.sv
src/exu_ctrl.sv
src/exu_issue_reg.sv
src/exu_operand_sel.sv
src/exu_alu.sv
src/exu_csr_wdata.sv
src/exu_top.sv
verification/exu_properties.sv
verification/tb_exu.sv

/* Bender.yml */
package:
  name: exu

sources:
  - src/exu_pkg.sv
  - src/exu_ctrl.sv
  - src/exu_issue_reg.sv
  - src/exu_operand_sel.sv
  - src/exu_alu.sv
  - src/exu_csr_wdata.sv
  - src/exu_top.sv
  - target: test
    files:
      - verification/exu_properties.sv
      - verification/tb_exu.sv
